// File: Bender.yml
package:
  name: dag

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/dagPkg.sv
      - design/dagOpIf.sv
      - design/dagRegFile.sv
      - design/dagOpQueue.sv
      - design/dagPostModify.sv
      - design/dagTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/dagTb.sv

// File: all.f
+incdir+include
design/dagPkg.sv
design/dagOpIf.sv
design/dagRegFile.sv
design/dagOpQueue.sv
design/dagPostModify.sv
design/dagTop.sv
tb/dagTb.sv

// File: design/dagOpIf.sv
`timescale 1ns/1ps

// operand item passed between stages under valid/ready.
interface dagOpIf;
  import dagPkg::*;

  logic   valid;
  logic   ready;
  // I register that receives the post-modified value.
  regIdx  iSel;
  dagWord iVal;
  dagWord lVal;
  dagWord mVal;

  modport src (
    output valid, iSel, iVal, lVal, mVal,
    input  ready
  );

  modport dst (
    input  valid, iSel, iVal, lVal, mVal,
    output ready
  );

endinterface

// File: design/dagOpQueue.sv
`timescale 1ns/1ps
`include "dag_consts.svh"

module dagOpQueue (
  input logic DSPCLK,
  input logic RST,
  dagOpIf.dst inBus,
  dagOpIf.src outBus
);
  import dagPkg::*;

  localparam int ptrWidth = $clog2(`QUEUE_DEPTH);

  regIdx  selMem [`QUEUE_DEPTH];
  dagWord iMem [`QUEUE_DEPTH];
  dagWord lMem [`QUEUE_DEPTH];
  dagWord mMem [`QUEUE_DEPTH];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth:0] count;
  logic push;
  logic pop;

  function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] p);
    if (p == ptrWidth'(`QUEUE_DEPTH - 1))
      return '0;
    return p + 1'b1;
  endfunction

  assign inBus.ready = (count != `QUEUE_DEPTH);
  assign outBus.valid = (count != '0);
  assign push = inBus.valid && inBus.ready;
  assign pop = outBus.valid && outBus.ready;

  // head entry is shown directly.
  assign outBus.iSel = selMem[rdPtr];
  assign outBus.iVal = iMem[rdPtr];
  assign outBus.lVal = lMem[rdPtr];
  assign outBus.mVal = mMem[rdPtr];

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= nextPtr(wrPtr);
      if (pop)
        rdPtr <= nextPtr(rdPtr);
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge DSPCLK)
  begin
    if (push)
    begin
      selMem[wrPtr] <= inBus.iSel;
      iMem[wrPtr] <= inBus.iVal;
      lMem[wrPtr] <= inBus.lVal;
      mMem[wrPtr] <= inBus.mVal;
    end
  end

  countRange: assert property (@(posedge DSPCLK) disable iff (RST) count <= `QUEUE_DEPTH);

endmodule

// File: design/dagPkg.sv
package dagPkg;

`include "dag_consts.svh"

  // one address register value.
  typedef logic [`DAG_WIDTH-1:0] dagWord;

  // host data bus value.
  typedef logic [`DMD_WIDTH-1:0] dmdWord;

  // register number inside a group, 0 is register 4.
  typedef logic [$clog2(`DAG_REGS)-1:0] regIdx;

  // bank select for host write and readback.
  typedef enum logic [1:0]
  {
    grpI = 2'd0,
    grpL = 2'd1,
    grpM = 2'd2
  } regGroup;

endpackage

// File: design/dagPostModify.sv
`timescale 1ns/1ps
`include "dag_consts.svh"

module dagPostModify (
  input  logic           DSPCLK,
  input  logic           RST,
  dagOpIf.dst            opBus,
  output logic           pmaValid,
  input  logic           pmaReady,
  output dagPkg::dagWord pma,
  output logic           wbEn,
  output dagPkg::regIdx  wbIdx,
  output dagPkg::dagWord wbData
);
  import dagPkg::*;

  logic take;
  dagWord nextI;

  // ones below the top bit of len-1, i.e. the low k bits with 2^k >= len.
  function automatic dagWord circMask(input dagWord len);
    dagWord lenM1;
    dagWord mask;
    lenM1 = len - 1'b1;
    mask[`DAG_WIDTH-1] = lenM1[`DAG_WIDTH-1];
    for (int b = `DAG_WIDTH - 2; b >= 0; b--)
      mask[b] = mask[b+1] | lenM1[b];
    return mask;
  endfunction

  function automatic dagWord modifyIndex(input dagWord iv, input dagWord lv, input dagWord mv);
    logic signed [`DAG_WIDTH+1:0] sum;
    logic signed [`DAG_WIDTH+1:0] base;
    logic signed [`DAG_WIDTH+1:0] len;
    sum = $signed({2'b00, iv}) + $signed({{2{mv[`DAG_WIDTH-1]}}, mv});
    if (lv == '0)
      return sum[`DAG_WIDTH-1:0];
    base = $signed({2'b00, iv & ~circMask(lv)});
    len = $signed({2'b00, lv});
    // wrap back into [base, base+len).
    if (sum >= base + len)
      sum = sum - len;
    else if (sum < base)
      sum = sum + len;
    return sum[`DAG_WIDTH-1:0];
  endfunction

  assign opBus.ready = !pmaValid || pmaReady;
  assign take = opBus.valid && opBus.ready;
  assign nextI = modifyIndex(opBus.iVal, opBus.lVal, opBus.mVal);

  // writeback goes out when the address is consumed.
  assign wbEn = pmaValid && pmaReady;

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
      pmaValid <= 1'b0;
    else if (take)
      pmaValid <= 1'b1;
    else if (pmaReady)
      pmaValid <= 1'b0;
  end

  always_ff @(posedge DSPCLK)
  begin
    if (take)
    begin
      pma <= opBus.iVal;
      wbIdx <= opBus.iSel;
      wbData <= nextI;
    end
  end

  pmaHold: assert property (@(posedge DSPCLK) disable iff (RST)
    pmaValid && !pmaReady |=> pmaValid && $stable(pma) && $stable(wbData));

endmodule

// File: design/dagRegFile.sv
`timescale 1ns/1ps
`include "dag_consts.svh"

module dagRegFile (
  input  logic            DSPCLK,
  input  logic            RST,
  input  logic            wrEn,
  input  dagPkg::regGroup wrGroup,
  input  dagPkg::regIdx   wrIdx,
  input  dagPkg::dagWord  wrData,
  input  logic            rdEn,
  input  dagPkg::regGroup rdGroup,
  input  dagPkg::regIdx   rdIdx,
  output dagPkg::dmdWord  dmd,
  input  logic            reqValid,
  output logic            reqReady,
  input  dagPkg::regIdx   reqI,
  input  dagPkg::regIdx   reqM,
  input  logic            wbEn,
  input  dagPkg::regIdx   wbIdx,
  input  dagPkg::dagWord  wbData,
  dagOpIf.src             fetchBus
);
  import dagPkg::*;

  dagWord iReg [`DAG_REGS];
  dagWord lReg [`DAG_REGS];
  dagWord mReg [`DAG_REGS];
  logic [`DAG_REGS-1:0] busy;
  logic reqTake;
  logic wbKeep;

  // the item slot frees when empty or when it transfers this edge.
  assign reqReady = (!fetchBus.valid || fetchBus.ready) && !busy[reqI];
  assign reqTake = reqValid && reqReady;

  // a host write to the same I register wins over writeback.
  assign wbKeep = wbEn && !(wrEn && (wrGroup == grpI) && (wrIdx == wbIdx));

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      for (int r = 0; r < `DAG_REGS; r++)
      begin
        iReg[r] <= '0;
        lReg[r] <= '0;
        mReg[r] <= '0;
      end
    end
    else
    begin
      if (wbKeep)
        iReg[wbIdx] <= wbData;
      if (wrEn)
      begin
        case (wrGroup)
          grpI: iReg[wrIdx] <= wrData;
          grpL: lReg[wrIdx] <= wrData;
          grpM: mReg[wrIdx] <= wrData;
          default: ;
        endcase
      end
    end
  end

  // busy covers the time from acceptance to writeback.
  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
      busy <= '0;
    else
    begin
      if (wbEn)
        busy[wbIdx] <= 1'b0;
      if (reqTake)
        busy[reqI] <= 1'b1;
    end
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
      fetchBus.valid <= 1'b0;
    else if (reqTake)
      fetchBus.valid <= 1'b1;
    else if (fetchBus.ready)
      fetchBus.valid <= 1'b0;
  end

  always_ff @(posedge DSPCLK)
  begin
    if (reqTake)
    begin
      fetchBus.iSel <= reqI;
      fetchBus.iVal <= iReg[reqI];
      fetchBus.lVal <= lReg[reqI];
      fetchBus.mVal <= mReg[reqM];
    end
  end

  // M is signed on the bus, I and L are not.
  always_comb
  begin
    dmd = '0;
    if (rdEn)
    begin
      case (rdGroup)
        grpI: dmd = {{(`DMD_WIDTH-`DAG_WIDTH){1'b0}}, iReg[rdIdx]};
        grpL: dmd = {{(`DMD_WIDTH-`DAG_WIDTH){1'b0}}, lReg[rdIdx]};
        grpM: dmd = {{(`DMD_WIDTH-`DAG_WIDTH){mReg[rdIdx][`DAG_WIDTH-1]}}, mReg[rdIdx]};
        default: dmd = '0;
      endcase
    end
  end

  // writeback comes from post-modify, only for an item this block issued.
  wbBusy: assert property (@(posedge DSPCLK) disable iff (RST) wbEn |-> busy[wbIdx]);

  fetchHold: assert property (@(posedge DSPCLK) disable iff (RST)
    fetchBus.valid && !fetchBus.ready |=> fetchBus.valid && $stable(fetchBus.iSel)
      && $stable(fetchBus.iVal) && $stable(fetchBus.lVal) && $stable(fetchBus.mVal));

endmodule

// File: design/dagTop.sv
`timescale 1ns/1ps

module dagTop (
  input  logic            DSPCLK,
  input  logic            RST,
  input  logic            wrEn,
  input  dagPkg::regGroup wrGroup,
  input  dagPkg::regIdx   wrIdx,
  input  dagPkg::dagWord  wrData,
  input  logic            rdEn,
  input  dagPkg::regGroup rdGroup,
  input  dagPkg::regIdx   rdIdx,
  output dagPkg::dmdWord  dmd,
  input  logic            reqValid,
  output logic            reqReady,
  input  dagPkg::regIdx   reqI,
  input  dagPkg::regIdx   reqM,
  output logic            pmaValid,
  input  logic            pmaReady,
  output dagPkg::dagWord  pma
);
  import dagPkg::*;

  logic wbEn;
  regIdx wbIdx;
  dagWord wbData;

  dagOpIf fetchBus ();
  dagOpIf issueBus ();

  dagRegFile regFile (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .wrEn     (wrEn),
    .wrGroup  (wrGroup),
    .wrIdx    (wrIdx),
    .wrData   (wrData),
    .rdEn     (rdEn),
    .rdGroup  (rdGroup),
    .rdIdx    (rdIdx),
    .dmd      (dmd),
    .reqValid (reqValid),
    .reqReady (reqReady),
    .reqI     (reqI),
    .reqM     (reqM),
    .wbEn     (wbEn),
    .wbIdx    (wbIdx),
    .wbData   (wbData),
    .fetchBus (fetchBus.src)
  );

  dagOpQueue opQueue (
    .DSPCLK (DSPCLK),
    .RST    (RST),
    .inBus  (fetchBus.dst),
    .outBus (issueBus.src)
  );

  // new I returns to the register file on the output handshake.
  dagPostModify postMod (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .opBus    (issueBus.dst),
    .pmaValid (pmaValid),
    .pmaReady (pmaReady),
    .pma      (pma),
    .wbEn     (wbEn),
    .wbIdx    (wbIdx),
    .wbData   (wbData)
  );

endmodule

// File: include/dag_consts.svh
`ifndef DAG_CONSTS_SVH
`define DAG_CONSTS_SVH

// width of the I, L and M registers and of the program memory address.
`define DAG_WIDTH 14

// data bus width for host readback.
`define DMD_WIDTH 16

// registers per group, I4..I7 and so on.
`define DAG_REGS 4

// operand items held between fetch and post-modify.
`define QUEUE_DEPTH 2

`endif

// File: tb/dagTb.sv
`timescale 1ns/1ps
`include "dag_consts.svh"

module dagTb;
  import dagPkg::*;

  // summed test lengths come to under 1000 cycles.
  localparam int cycleLimit = 4000;

  logic DSPCLK = 1'b0;
  logic RST;
  logic wrEn;
  regGroup wrGroup;
  regIdx wrIdx;
  dagWord wrData;
  logic rdEn;
  regGroup rdGroup;
  regIdx rdIdx;
  dmdWord dmd;
  logic reqValid;
  logic reqReady;
  regIdx reqI;
  regIdx reqM;
  logic pmaValid;
  logic pmaReady;
  dagWord pma;

  integer seed = 32'ha5c1;
  int cycles = 0;
  dagWord modelI [`DAG_REGS];
  dagWord modelL [`DAG_REGS];
  dagWord modelM [`DAG_REGS];
  regIdx reqIQ [$];
  regIdx reqMQ [$];
  dagWord expPma [$];
  regIdx expIdx [$];

  dagTop i_dut (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .wrEn     (wrEn),
    .wrGroup  (wrGroup),
    .wrIdx    (wrIdx),
    .wrData   (wrData),
    .rdEn     (rdEn),
    .rdGroup  (rdGroup),
    .rdIdx    (rdIdx),
    .dmd      (dmd),
    .reqValid (reqValid),
    .reqReady (reqReady),
    .reqI     (reqI),
    .reqM     (reqM),
    .pmaValid (pmaValid),
    .pmaReady (pmaReady),
    .pma      (pma)
  );

  always #4 DSPCLK = ~DSPCLK;

  always @(posedge DSPCLK)
  begin
    cycles = cycles + 1;
    if (cycles >= cycleLimit)
    begin
      $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
      failRun();
    end
  end

  task automatic failRun();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic checkWord(input string name, input dagWord exp, input dagWord act);
    if (exp !== act)
    begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      failRun();
    end
  endtask

  task automatic checkDmd(input string name, input dmdWord exp, input dmdWord act);
    if (exp !== act)
    begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      failRun();
    end
  endtask

  task automatic checkIdx(input string name, input regIdx exp, input regIdx act);
    if (exp !== act)
    begin
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
      failRun();
    end
  endtask

  // reference post-modify, linear when len is zero.
  function automatic dagWord modelNext(input dagWord iv, input dagWord lv, input dagWord mv);
    int n;
    int len;
    int k;
    int base;
    n = int'(iv) + int'($signed(mv));
    len = int'(lv);
    if (len != 0)
    begin
      k = 0;
      while ((1 << k) < len)
        k++;
      base = int'(iv) - (int'(iv) % (1 << k));
      if (n >= base + len)
        n = n - len;
      else if (n < base)
        n = n + len;
    end
    return dagWord'(n);
  endfunction

  task automatic writeReg(input regGroup g, input regIdx idx, input dagWord v);
    @(negedge DSPCLK);
    wrEn = 1'b1;
    wrGroup = g;
    wrIdx = idx;
    wrData = v;
    case (g)
      grpI: modelI[idx] = v;
      grpL: modelL[idx] = v;
      default: modelM[idx] = v;
    endcase
    @(negedge DSPCLK);
    wrEn = 1'b0;
  endtask

  task automatic readCheck(input string name, input regGroup g, input regIdx idx);
    dmdWord exp;
    @(negedge DSPCLK);
    rdEn = 1'b1;
    rdGroup = g;
    rdIdx = idx;
    case (g)
      grpI: exp = dmdWord'(modelI[idx]);
      grpL: exp = dmdWord'(modelL[idx]);
      default: exp = dmdWord'($signed(modelM[idx]));
    endcase
    #1;
    checkDmd(name, exp, dmd);
  endtask

  task automatic queueRequest(input regIdx i, input regIdx m);
    reqIQ.push_back(i);
    reqMQ.push_back(m);
    expPma.push_back(modelI[i]);
    expIdx.push_back(i);
    modelI[i] = modelNext(modelI[i], modelL[i], modelM[m]);
  endtask

  // issues the queued requests and checks every output in order.
  task automatic runRequests(input string name, input bit randomReady);
    int sent;
    int got;
    int rnd;
    sent = 0;
    got = 0;
    while (got < expPma.size())
    begin
      @(negedge DSPCLK);
      reqValid = (sent < reqIQ.size());
      if (reqValid)
      begin
        reqI = reqIQ[sent];
        reqM = reqMQ[sent];
      end
      rnd = $random(seed);
      pmaReady = randomReady ? rnd[0] : 1'b1;
      #1;
      if (reqValid && reqReady)
        sent++;
      if (pmaValid && pmaReady)
      begin
        checkWord(name, expPma[got], pma);
        checkIdx(name, expIdx[got], i_dut.wbIdx);
        got++;
      end
    end
    reqValid = 1'b0;
    repeat (6)
    begin
      @(negedge DSPCLK);
      pmaReady = 1'b1;
      if (pmaValid !== 1'b0)
      begin
        $display("%s: an extra address came out after all requests completed", name);
        failRun();
      end
    end
    reqIQ.delete();
    reqMQ.delete();
    expPma.delete();
    expIdx.delete();
  endtask

  task automatic afterReset();
    for (int r = 0; r < `DAG_REGS; r++)
    begin
      readCheck("reset I", grpI, regIdx'(r));
      readCheck("reset L", grpL, regIdx'(r));
      readCheck("reset M", grpM, regIdx'(r));
    end
    if (pmaValid !== 1'b0)
    begin
      $display("pmaValid is not low after reset");
      failRun();
    end
    if (reqReady !== 1'b1)
    begin
      $display("reqReady is not high after reset");
      failRun();
    end
  endtask

  task automatic writeAndRead();
    for (int r = 0; r < `DAG_REGS; r++)
    begin
      writeReg(grpI, regIdx'(r), dagWord'(14'h2a50 + r * 14'h0111));
      writeReg(grpL, regIdx'(r), dagWord'(14'h3800 | r));
      // odd M values have bit 13 set.
      writeReg(grpM, regIdx'(r), (r % 2) ? dagWord'(14'h2001 + r) : dagWord'(14'h0123 + r));
    end
    for (int r = 0; r < `DAG_REGS; r++)
    begin
      readCheck("readback I", grpI, regIdx'(r));
      readCheck("readback L", grpL, regIdx'(r));
      readCheck("readback M", grpM, regIdx'(r));
    end
    @(negedge DSPCLK);
    rdEn = 1'b0;
    rdGroup = grpM;
    rdIdx = 2'd1;
    #1;
    checkDmd("idle readback", '0, dmd);
  endtask

  task automatic linearMode();
    writeReg(grpL, 2'd0, 14'h0000);
    writeReg(grpI, 2'd0, 14'h3ff0);
    writeReg(grpM, 2'd0, 14'h0005);
    writeReg(grpM, 2'd1, 14'h3ffd);
    writeReg(grpM, 2'd2, 14'h0020);
    writeReg(grpM, 2'd3, 14'h3fe0);
    queueRequest(2'd0, 2'd0);
    queueRequest(2'd0, 2'd0);
    queueRequest(2'd0, 2'd2);
    queueRequest(2'd0, 2'd1);
    queueRequest(2'd0, 2'd3);
    queueRequest(2'd0, 2'd0);
    runRequests("linear", 1'b0);
    readCheck("linear final I", grpI, 2'd0);
  endtask

  task automatic circularMode();
    // buffer 0x100..0x109, so base uses the low four bits.
    writeReg(grpL, 2'd1, 14'd10);
    writeReg(grpI, 2'd1, 14'h0107);
    writeReg(grpM, 2'd0, 14'h0003);
    writeReg(grpM, 2'd1, 14'h3ffc);
    repeat (3)
      queueRequest(2'd1, 2'd0);
    repeat (3)
      queueRequest(2'd1, 2'd1);
    queueRequest(2'd1, 2'd0);
    runRequests("circular", 1'b0);
    readCheck("circular final I", grpI, 2'd1);
  endtask

  task automatic backPressure();
    int rnd;
    writeReg(grpI, 2'd0, 14'h0200);
    writeReg(grpL, 2'd0, 14'd0);
    writeReg(grpI, 2'd1, 14'h0105);
    writeReg(grpL, 2'd1, 14'd10);
    writeReg(grpI, 2'd2, 14'h0033);
    writeReg(grpL, 2'd2, 14'd7);
    writeReg(grpI, 2'd3, 14'h1000);
    writeReg(grpL, 2'd3, 14'd0);
    writeReg(grpM, 2'd0, 14'h0001);
    writeReg(grpM, 2'd1, 14'h3ffe);
    writeReg(grpM, 2'd2, 14'h0003);
    writeReg(grpM, 2'd3, 14'h3ffb);
    repeat (40)
    begin
      rnd = $random(seed);
      queueRequest(rnd[1:0], rnd[3:2]);
    end
    runRequests("back-pressure", 1'b1);
    for (int r = 0; r < `DAG_REGS; r++)
      readCheck("back-pressure final I", grpI, regIdx'(r));
  endtask

  initial
  begin
    RST = 1'b1;
    wrEn = 1'b0;
    wrGroup = grpI;
    wrIdx = '0;
    wrData = '0;
    rdEn = 1'b0;
    rdGroup = grpI;
    rdIdx = '0;
    reqValid = 1'b0;
    reqI = '0;
    reqM = '0;
    pmaReady = 1'b0;
    for (int r = 0; r < `DAG_REGS; r++)
    begin
      modelI[r] = '0;
      modelL[r] = '0;
      modelM[r] = '0;
    end
    repeat (16) @(posedge DSPCLK);
    @(negedge DSPCLK);
    RST = 1'b0;
    afterReset();
    writeAndRead();
    linearMode();
    circularMode();
    backPressure();
    $display("PASS: all tests");
    $finish;
  end

endmodule
